/* hw/fv_pkg.sv */
// Feature vector bank types
package fv_pkg;

    localparam int FV_WORD_W = 16;
    localparam int FV_BYTE_W = FV_WORD_W / 2;

    // The top level's NUM_EDGE_PE must fit in PE_TAG_W, and its SRAM depth is set by FV_ADDR_W.
    localparam int FV_ADDR_W = 8;
    localparam int PE_TAG_W  = 2;

    typedef struct packed {
        logic [FV_BYTE_W-1:0] hi;   // Element 2k+1.
        logic [FV_BYTE_W-1:0] lo;   // Element 2k.
    } fv_bytes_t;

    typedef union packed {
        logic [FV_WORD_W-1:0] word;
        fv_bytes_t            bytes;
    } fv_word_u;

    typedef struct packed {
        logic                 valid;
        logic                 sos;
        logic                 eos;
        logic [FV_ADDR_W-1:0] addr;
        fv_word_u             data;
    } fv_load_t;

    typedef struct packed {
        logic                 valid;
        logic [FV_ADDR_W-1:0] addr;   // First word of the vector.
        logic [PE_TAG_W-1:0]  pe_tag;
    } fv_rd_req_t;

    typedef struct packed {
        logic                 cen;   // Active low.
        logic                 wen;   // Active low.
        logic [FV_ADDR_W-1:0] a;
        fv_word_u             d;
    } fv_sram_if_t;

    typedef struct packed {
        logic                valid;
        logic                sos;
        logic                eos;
        logic [PE_TAG_W-1:0] pe_tag;
        fv_word_u            data;
    } fv_pe_beat_t;

endpackage

/* hw/fv_sram.sv */
// Single-port feature SRAM
`timescale 1ns/1ps

module fv_sram
    import fv_pkg::*;
#(
    parameter int DEPTH = 2 ** FV_ADDR_W
) (
    input  logic        clk,
    input  fv_sram_if_t sram,
    output fv_word_u    q
);

    fv_word_u mem [DEPTH];

    // One access per cycle; q keeps the last word read.
    always_ff @(posedge clk) begin
        if (!sram.cen) begin
            if (!sram.wen) begin
                mem[sram.a] <= sram.d;
            end else begin
                q <= mem[sram.a];
            end
        end
    end

endmodule

/* hw/fv_bank_ctrl.sv */
// Feature vector bank controller
`timescale 1ns/1ps

module fv_bank_ctrl
    import fv_pkg::*;
#(
    parameter int MAX_FV_NUM = 32
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [$clog2(MAX_FV_NUM):0] num_fv,
    input  fv_load_t                    load,
    input  fv_rd_req_t                  launch,
    input  fv_word_u                    q,
    output fv_sram_if_t                 sram,
    output fv_pe_beat_t                 pe_out,
    output logic                        launch_taken,
    output logic                        ctrl_idle,
    output logic                        load_ready,
    output logic                        busy
);

    localparam int NUM_W = $clog2(MAX_FV_NUM) + 1;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        STREAM
    } state_t;

    typedef struct packed {
        logic valid;
        logic sos;
        logic eos;
        logic odd;   // Last word of an odd count.
    } rd_flags_t;

    state_t              state;
    state_t              nx_state;
    fv_sram_if_t         nx_sram;
    fv_sram_if_t         load_wr;
    rd_flags_t           issue;   // Flags of the read now on the SRAM port.
    rd_flags_t           nx_issue;
    rd_flags_t           s1;      // Same flags, aligned with q.
    fv_pe_beat_t         nx_pe_out;
    logic [PE_TAG_W-1:0] tag_r;
    logic [PE_TAG_W-1:0] nx_tag;
    logic [NUM_W-1:0]    elem_cnt;
    logic [NUM_W-1:0]    nx_elem_cnt;
    logic                load_acc;

    // Idle only once the read pipeline has drained.
    assign ctrl_idle    = (state == IDLE) && !s1.valid && !pe_out.valid;
    assign load_ready   = ctrl_idle || (state == LOAD);
    assign load_acc     = load.valid && load_ready;
    assign launch_taken = launch.valid && ctrl_idle && !(load.valid && load.sos);
    assign busy         = s1.valid || pe_out.valid;

    assign load_wr = '{cen: 1'b0, wen: 1'b0, a: load.addr, d: load.data};

    always_comb begin
        nx_state    = state;
        nx_sram     = sram;
        nx_sram.cen = 1'b1;
        nx_sram.wen = 1'b1;
        nx_issue    = '0;
        nx_tag      = tag_r;
        nx_elem_cnt = elem_cnt;
        case (state)
            IDLE: begin
                if (load_acc && load.sos) begin
                    nx_sram = load_wr;
                    if (!load.eos) begin
                        nx_state = LOAD;
                    end
                end else if (launch_taken) begin
                    nx_sram.cen    = 1'b0;
                    nx_sram.a      = launch.addr;
                    nx_tag         = launch.pe_tag;
                    nx_elem_cnt    = NUM_W'(2);
                    nx_issue.valid = 1'b1;
                    nx_issue.sos   = 1'b1;
                    nx_state       = STREAM;
                end
            end
            LOAD: begin
                if (load_acc) begin
                    nx_sram = load_wr;
                    if (load.eos) begin
                        nx_state = IDLE;
                    end
                end
            end
            STREAM: begin
                if (issue.eos) begin
                    nx_state = IDLE;
                end else begin
                    nx_sram.cen    = 1'b0;
                    nx_sram.a      = sram.a + 1'b1;
                    nx_elem_cnt    = elem_cnt + NUM_W'(2);
                    nx_issue.valid = 1'b1;
                end
            end
            default: begin
                nx_state = IDLE;
            end
        endcase
        // The counter holds the elements covered up to the word being issued.
        if (nx_issue.valid) begin
            nx_issue.eos = (nx_elem_cnt >= num_fv);
            nx_issue.odd = nx_issue.eos && num_fv[0];
        end
    end

    always_comb begin
        nx_pe_out = '0;
        if (s1.valid) begin
            nx_pe_out.valid  = 1'b1;
            nx_pe_out.sos    = s1.sos;
            nx_pe_out.eos    = s1.eos;
            nx_pe_out.pe_tag = tag_r;
            nx_pe_out.data   = q;
            if (s1.odd) begin
                nx_pe_out.data.bytes.hi = '0;   // Only the low element is real.
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= IDLE;
            sram     <= '{cen: 1'b1, wen: 1'b1, a: '0, d: '0};
            issue    <= '0;
            s1       <= '0;
            pe_out   <= '0;
            tag_r    <= '0;
            elem_cnt <= '0;
        end else begin
            state    <= nx_state;
            sram     <= nx_sram;
            issue    <= nx_issue;
            s1       <= issue;
            pe_out   <= nx_pe_out;
            tag_r    <= nx_tag;
            elem_cnt <= nx_elem_cnt;
        end
    end

    a_no_write_in_stream: assert property (@(posedge clk) disable iff (!reset)
        (state == STREAM || busy) |-> sram.wen)
        else $error("SRAM write while a stream is in flight.");

    a_no_load_in_stream: assert property (@(posedge clk) disable iff (!reset)
        (state == STREAM || busy) |-> !load_acc)
        else $error("Load beat accepted during a stream.");

    a_eos_then_gap: assert property (@(posedge clk) disable iff (!reset)
        (pe_out.valid && pe_out.eos) |=> (!pe_out.valid || pe_out.sos))
        else $error("Beat after eos without a new sos.");

endmodule

/* hw/fv_read_dispatch.sv */
// Credit-based read dispatcher
`timescale 1ns/1ps

module fv_read_dispatch
    import fv_pkg::*;
#(
    parameter int MAX_FV_NUM  = 32,
    parameter int NUM_EDGE_PE = 4,
    parameter int PE_CREDITS  = 16
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [$clog2(MAX_FV_NUM):0] num_fv,
    input  fv_rd_req_t                  rd_req,
    input  logic [NUM_EDGE_PE-1:0]      credit_return,
    input  logic                        ctrl_idle,
    input  logic                        launch_taken,
    output logic                        rd_ready,
    output fv_rd_req_t                  launch
);

    localparam int NUM_W  = $clog2(MAX_FV_NUM) + 1;
    localparam int CRED_W = $clog2(PE_CREDITS + 1);

    logic [NUM_W-1:0]  fv_words;
    logic [CRED_W-1:0] words;
    logic [CRED_W-1:0] credits [NUM_EDGE_PE];
    logic              credit_ok;

    if (PE_CREDITS < (MAX_FV_NUM + 1) / 2) begin : g_credit_check
        $error("PE_CREDITS cannot hold the largest vector.");
    end

    if (NUM_EDGE_PE > 2 ** PE_TAG_W) begin : g_tag_check
        $error("NUM_EDGE_PE does not fit in PE_TAG_W.");
    end

    // Two elements per word, rounded up.
    assign fv_words  = (num_fv + NUM_W'(1)) >> 1;
    assign words     = CRED_W'(fv_words);
    assign credit_ok = (credits[rd_req.pe_tag] >= words);

    assign launch.valid  = rd_req.valid && ctrl_idle && credit_ok;
    assign launch.addr   = rd_req.addr;
    assign launch.pe_tag = rd_req.pe_tag;

    // A launch refused for a load start holds the request back.
    assign rd_ready = ctrl_idle && credit_ok && (launch_taken || !launch.valid);

    for (genvar i = 0; i < NUM_EDGE_PE; i++) begin : g_pe
        logic take;

        assign take = launch_taken && (launch.pe_tag == PE_TAG_W'(i));

        always_ff @(posedge clk or negedge reset) begin
            if (!reset) begin
                credits[i] <= CRED_W'(PE_CREDITS);
            end else begin
                credits[i] <= credits[i] + CRED_W'(credit_return[i]) - (take ? words : '0);
            end
        end

        a_credit_max: assert property (@(posedge clk) disable iff (!reset)
            credits[i] <= CRED_W'(PE_CREDITS))
            else $error("PE %0d returned more credit than its buffer holds.", i);

        // A wrap below zero would leave the counter above its old value.
        a_credit_min: assert property (@(posedge clk) disable iff (!reset)
            take |=> credits[i] <= $past(credits[i]))
            else $error("PE %0d credit counter wrapped below zero.", i);
    end

endmodule

/* hw/fv_bank_top.sv */
// Feature vector bank top level
`timescale 1ns/1ps

module fv_bank_top
    import fv_pkg::*;
#(
    parameter int MAX_FV_NUM  = 32,
    parameter int NUM_EDGE_PE = 4,
    parameter int PE_CREDITS  = 16
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [$clog2(MAX_FV_NUM):0] num_fv,
    input  fv_load_t                    load,
    input  fv_rd_req_t                  rd_req,
    input  logic [NUM_EDGE_PE-1:0]      credit_return,
    output logic                        load_ready,
    output logic                        rd_ready,
    output fv_pe_beat_t                 pe_out,
    output logic                        busy
);

    fv_rd_req_t  launch;
    logic        launch_taken;
    logic        ctrl_idle;
    fv_sram_if_t sram;
    fv_word_u    q;

    fv_read_dispatch #(
        .MAX_FV_NUM  (MAX_FV_NUM),
        .NUM_EDGE_PE (NUM_EDGE_PE),
        .PE_CREDITS  (PE_CREDITS)
    ) u_dispatch (
        .clk           (clk),
        .reset         (reset),
        .num_fv        (num_fv),
        .rd_req        (rd_req),
        .credit_return (credit_return),
        .ctrl_idle     (ctrl_idle),
        .launch_taken  (launch_taken),
        .rd_ready      (rd_ready),
        .launch        (launch)
    );

    fv_bank_ctrl #(
        .MAX_FV_NUM (MAX_FV_NUM)
    ) u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .num_fv       (num_fv),
        .load         (load),
        .launch       (launch),
        .q            (q),
        .sram         (sram),
        .pe_out       (pe_out),
        .launch_taken (launch_taken),
        .ctrl_idle    (ctrl_idle),
        .load_ready   (load_ready),
        .busy         (busy)
    );

    fv_sram u_sram (
        .clk  (clk),
        .sram (sram),
        .q    (q)
    );

endmodule

/* dv/tb_fv_bank.sv */
// Feature vector bank testbench
`timescale 1ns/1ps

module tb_fv_bank
    import fv_pkg::*;
();

    localparam int MAX_FV_NUM   = 32;
    localparam int NUM_EDGE_PE  = 4;
    localparam int PE_CREDITS   = 16;
    localparam int NUM_W        = $clog2(MAX_FV_NUM) + 1;
    localparam int CLK_PERIOD   = 100;
    localparam int PIPE_LEN     = 8;
    localparam int ACCEPT_LIMIT = 64;
    // Reset, then the five tests, then a margin.
    localparam int RUN_CYCLES   = 20 + 300 + 100 + 150 + 150 + 100 + 200;

    logic                   clk;
    logic                   reset;
    logic [NUM_W-1:0]       num_fv;
    fv_load_t               load;
    fv_rd_req_t             rd_req;
    logic [NUM_EDGE_PE-1:0] credit_return;
    logic                   load_ready;
    logic                   rd_ready;
    fv_pe_beat_t            pe_out;
    logic                   busy;

    fv_word_u               shadow [2 ** FV_ADDR_W];
    logic [NUM_EDGE_PE-1:0] ret_pipe [PIPE_LEN];   // Credit returns still to be sent.
    int                     tb_cred [NUM_EDGE_PE];
    int                     ret_delay;
    bit                     pe_return_on;
    integer                 seed;
    int                     n_checks;
    int                     n_errors;

    fv_bank_top #(
        .MAX_FV_NUM  (MAX_FV_NUM),
        .NUM_EDGE_PE (NUM_EDGE_PE),
        .PE_CREDITS  (PE_CREDITS)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish.", RUN_CYCLES);
        $display("Test failed");
        $finish;
    end

    // Edge PE model: each beat received frees one buffer word ret_delay cycles later.
    always @(negedge clk) begin : pe_model
        int d;
        if (pe_return_on) begin
            credit_return = ret_pipe[0];
            for (d = 0; d < PIPE_LEN - 1; d++) begin
                ret_pipe[d] = ret_pipe[d+1];
            end
            ret_pipe[PIPE_LEN-1] = '0;
            if (pe_out.valid) begin
                ret_pipe[ret_delay-1][pe_out.pe_tag] = 1'b1;
            end
        end
    end

    task automatic check_beat(input string name, input fv_pe_beat_t got, input fv_pe_beat_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_credit_block(input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail rd_ready: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic fv_pe_beat_t expected_beat(input logic [FV_ADDR_W-1:0] addr,
            input logic [PE_TAG_W-1:0] tag, input int nfv, input int k);
        fv_pe_beat_t b;
        int          last;
        last     = (nfv + 1) / 2 - 1;
        b.valid  = 1'b1;
        b.sos    = (k == 0);
        b.eos    = (k == last);
        b.pe_tag = tag;
        b.data   = shadow[addr + FV_ADDR_W'(k)];
        if (k == last && nfv % 2 == 1) begin
            b.data.bytes.hi = '0;   // No element past the count.
        end
        return b;
    endfunction

    function automatic bit pipe_busy();
        bit any;
        int d;
        any = 1'b0;
        for (d = 0; d < PIPE_LEN; d++) begin
            any |= (ret_pipe[d] != '0);
        end
        return any;
    endfunction

    task automatic load_frame(input logic [FV_ADDR_W-1:0] addr, input int n);
        fv_word_u w;
        int       k;
        for (k = 0; k < n; k++) begin
            @(negedge clk);
            check_flag("load_ready", load_ready, 1'b1);
            w.word = 16'($random(seed));
            load   = '{valid: 1'b1, sos: (k == 0), eos: (k == n - 1),
                       addr: addr + FV_ADDR_W'(k), data: w};
            shadow[addr + FV_ADDR_W'(k)] = w;
        end
        @(negedge clk);
        load = '0;
    endtask

    task automatic wait_accept(output bit ok, output int cycles);
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < ACCEPT_LIMIT) begin
            @(posedge clk);
            ok = rd_ready;
            cycles++;
        end
    endtask

    // Entered right after the accepting edge; word 0 is due two edges later.
    task automatic check_stream(input logic [FV_ADDR_W-1:0] addr,
            input logic [PE_TAG_W-1:0] tag, input int nfv);
        int k;
        @(negedge clk);
        rd_req = '0;
        check_flag("pe_out.valid", pe_out.valid, 1'b0);
        @(negedge clk);
        check_flag("pe_out.valid", pe_out.valid, 1'b0);
        check_flag("busy", busy, 1'b1);
        for (k = 0; k < (nfv + 1) / 2; k++) begin
            @(negedge clk);
            check_beat($sformatf("pe_out[%0d]", k), pe_out, expected_beat(addr, tag, nfv, k));
            check_flag("busy", busy, 1'b1);
            check_flag("load_ready", load_ready, 1'b0);
        end
        @(negedge clk);
        check_flag("pe_out.valid", pe_out.valid, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("load_ready", load_ready, 1'b1);
        if (!pe_return_on) begin
            tb_cred[tag] -= (nfv + 1) / 2;
        end
    endtask

    task automatic issue_read(input logic [FV_ADDR_W-1:0] addr,
            input logic [PE_TAG_W-1:0] tag, input int nfv);
        bit ok;
        int cycles;
        @(negedge clk);
        num_fv = NUM_W'(nfv);
        rd_req = '{valid: 1'b1, addr: addr, pe_tag: tag};
        wait_accept(ok, cycles);
        if (ok) begin
            check_stream(addr, tag, nfv);
        end else begin
            n_errors++;
            $display("Read of address %h for PE %0d was never accepted.", addr, tag);
            @(negedge clk);
            rd_req = '0;
        end
    endtask

    // Called on a falling edge while the PE model is off.
    task automatic give_credit(input int pe);
        credit_return[pe] = 1'b1;
        @(negedge clk);
        credit_return[pe] = 1'b0;
        tb_cred[pe]++;
    endtask

    task automatic drain_returns();
        int i;
        @(posedge clk);
        while (pipe_busy()) begin
            @(posedge clk);
        end
        @(negedge clk);
        pe_return_on  = 1'b0;
        credit_return = '0;
        for (i = 0; i < NUM_EDGE_PE; i++) begin
            tb_cred[i] = PE_CREDITS;
        end
    endtask

    task automatic test_load_read();
        load_frame(8'h00, 16);
        load_frame(8'h20, 8);
        load_frame(8'h40, 4);
        load_frame(8'hf8, 8);
        issue_read(8'h00, 2'd0, 32);
        issue_read(8'h20, 2'd1, 16);
        issue_read(8'h40, 2'd2, 8);
        issue_read(8'hf8, 2'd3, 16);
    endtask

    task automatic test_odd_counts();
        load_frame(8'h80, 4);
        issue_read(8'h80, 2'd1, 7);
        issue_read(8'h81, 2'd2, 1);
        issue_read(8'h82, 2'd3, 2);
        issue_read(8'h80, 2'd0, 5);
    endtask

    task automatic test_credit_block();
        bit ok;
        int cycles;
        int i;
        drain_returns();
        for (i = 0; i < 3; i++) begin
            issue_read(8'h00, 2'd0, 10);
        end
        @(negedge clk);
        rd_req = '{valid: 1'b1, addr: 8'h00, pe_tag: 2'd0};
        repeat (3) begin
            @(negedge clk);
            check_credit_block(rd_ready, 1'b0);
        end
        while (tb_cred[0] < (10 + 1) / 2) begin
            give_credit(0);
            check_credit_block(rd_ready, tb_cred[0] >= (10 + 1) / 2);
        end
        wait_accept(ok, cycles);
        if (!ok || cycles != 1) begin
            n_errors++;
            $display("PE 0 request was not accepted on the first edge with enough credit.");
        end
        if (ok) begin
            check_stream(8'h00, 2'd0, 10);
        end else begin
            @(negedge clk);
            rd_req = '0;
        end
    endtask

    task automatic test_independent_pes();
        int pe;
        @(negedge clk);
        rd_req = '{valid: 1'b1, addr: 8'h00, pe_tag: 2'd0};   // PE 0 has no credit left.
        @(negedge clk);
        check_credit_block(rd_ready, 1'b0);
        rd_req = '0;
        issue_read(8'h00, 2'd1, 32);
        for (pe = 0; pe < NUM_EDGE_PE; pe++) begin
            while (tb_cred[pe] < PE_CREDITS) begin
                give_credit(pe);
            end
        end
        pe_return_on = 1'b1;
    endtask

    task automatic test_busy_gating();
        issue_read(8'h40, 2'd2, 8);
        load_frame(8'h40, 4);
        issue_read(8'h40, 2'd2, 8);
    endtask

    initial begin
        seed          = 32'hf2d953b2;
        n_checks      = 0;
        n_errors      = 0;
        pe_return_on  = 1'b1;
        ret_delay     = 3;
        reset         = 1'b0;
        num_fv        = NUM_W'(2);
        load          = '0;
        rd_req        = '0;
        credit_return = '0;
        foreach (ret_pipe[d]) begin
            ret_pipe[d] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        check_flag("pe_out.valid", pe_out.valid, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("load_ready", load_ready, 1'b1);
        check_credit_block(rd_ready, 1'b1);
        test_load_read();
        test_odd_counts();
        test_credit_block();
        test_independent_pes();
        test_busy_gating();
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* src.f */
hw/fv_pkg.sv
hw/fv_sram.sv
hw/fv_bank_ctrl.sv
hw/fv_read_dispatch.sv
hw/fv_bank_top.sv
dv/tb_fv_bank.sv
